/* periph_hub.f */
+incdir+tests
logic/periph_pkg.sv
logic/periph_decode.sv
logic/periph_read_buffer.sv
logic/gpio_ctrl.sv
logic/byte_reg_periph.sv
logic/pin_mux.sv
logic/periph_hub.sv
tests/tb_periph_hub.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the peripheral hub testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_periph_hub -f periph_hub.f -o sim_periph_hub
./obj_dir/sim_periph_hub | tee sim.log
if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tests/tb_periph_model.svh */
// Reference model of the hub's GPIO, pin select and byte register state
`ifndef TB_PERIPH_MODEL_SVH
`define TB_PERIPH_MODEL_SVH

logic [PIN_W-1:0]  m_gpio_out;
pin_sel_t          m_sel [PIN_W];
logic [BYTE_W-1:0] m_byte_a;
logic [BYTE_W-1:0] m_byte_b;

function automatic void reset_model();
    m_gpio_out = '0;
    m_byte_a   = '0;
    m_byte_b   = '0;
    for (int p = 0; p < PIN_W; p++) begin
        m_sel[p] = '{is_byte_slot: 1'b0, slot: SLOT_GPIO};  // Every pin starts on GPIO
    end
endfunction

// Word-spaced select registers from 0x20 up to 0x3C
function automatic logic is_sel_ofs(input logic [5:0] ofs);
    return (ofs >= GPIO_SEL_BASE) && (ofs[1:0] == 2'b00);
endfunction

function automatic void apply_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [PIN_IDX_W-1:0] pin;
    pin = addr[PIN_IDX_W+1:2];
    if (addr[10]) begin
        if (addr[7:4] == BYTE_SLOT_A && addr[3:0] == 4'h0) m_byte_a = wdata[BYTE_W-1:0];
        if (addr[7:4] == BYTE_SLOT_B && addr[3:0] == 4'h0) m_byte_b = wdata[BYTE_W-1:0];
    end else if (addr[9:6] == SLOT_GPIO) begin
        if (addr[5:0] == GPIO_OUT_OFS) begin
            m_gpio_out = wdata[PIN_W-1:0];
        end else if (is_sel_ofs(addr[5:0])) begin
            m_sel[pin] = pin_sel_t'(wdata[$bits(pin_sel_t)-1:0]);
        end
    end
endfunction

function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                    input logic [PIN_W-1:0] pins);
    logic [DATA_W-1:0] val;
    logic [5:0]        ofs;
    val = '0;
    ofs = addr[5:0];
    if (addr[10]) begin
        if (addr[7:4] == BYTE_SLOT_A || addr[7:4] == BYTE_SLOT_B) begin
            if (addr[3:0] == 4'h0) val[BYTE_W-1:0] = (addr[7:4] == BYTE_SLOT_A) ? m_byte_a : m_byte_b;
            if (addr[3:0] == 4'h1) val[PIN_W-1:0] = pins;
        end
    end else if (addr[9:6] == SLOT_GPIO) begin
        if (ofs == GPIO_OUT_OFS) val[PIN_W-1:0] = m_gpio_out;
        else if (ofs == GPIO_IN_OFS) val[PIN_W-1:0] = pins;
        else if (is_sel_ofs(ofs)) val[$bits(pin_sel_t)-1:0] = m_sel[ofs[PIN_IDX_W+1:2]];
    end
    return val;
endfunction

function automatic logic [PIN_W-1:0] expected_pins();
    logic [PIN_W-1:0] pins;
    pins = '0;
    for (int p = 0; p < PIN_W; p++) begin
        if (m_sel[p].is_byte_slot) begin
            if (m_sel[p].slot == BYTE_SLOT_A) pins[p] = m_byte_a[p];
            else if (m_sel[p].slot == BYTE_SLOT_B) pins[p] = m_byte_b[p];
        end else if (m_sel[p].slot == SLOT_GPIO) begin
            pins[p] = m_gpio_out[p];
        end
    end
    return pins;
endfunction

`endif

/* tests/tb_periph_hub.sv */
// Testbench for the peripheral hub with random bus traffic checked against a register model
`timescale 1ns/10ps
`default_nettype none

module tb_periph_hub;
    import periph_pkg::*;

    localparam int NUM_TXN     = 300;
    localparam int RST_CYCLES  = 4;
    localparam int CYCLE_LIMIT = NUM_TXN * 4 + RST_CYCLES + 100;   // Margin covers reset-state reads

    logic              clk;
    logic              rst_n;
    bus_req_t          req;
    logic              read_complete;
    logic [PIN_W-1:0]  pins_in;
    logic [DATA_W-1:0] data;
    logic              data_ready;
    logic [PIN_W-1:0]  pins_out;

    logic [31:0] rand_state;
    int          cycle_cnt;
    int          err_read;
    int          err_pins;
    int          err_ready;

    `include "tb_periph_model.svh"

    periph_hub UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_read_complete (read_complete),
        .i_pins_in       (pins_in),
        .o_data          (data),
        .o_data_ready    (data_ready),
        .o_pins          (pins_out)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_addr();
        logic [31:0] r;
        logic [3:0]  bofs;
        r    = next_rand();
        bofs = (r[21:20] == 2'd0) ? 4'h0 : (r[21:20] == 2'd1) ? 4'h1 : r[19:16];
        case (r[30:28])
            3'd0:       return {1'b0, SLOT_GPIO, GPIO_OUT_OFS};
            3'd1:       return {1'b0, SLOT_GPIO, GPIO_IN_OFS};
            3'd2, 3'd3: return {1'b0, SLOT_GPIO, 1'b1, r[26:24], 2'b00};
            3'd4:       return {1'b1, r[23:22], BYTE_SLOT_A, bofs};
            3'd5:       return {1'b1, r[23:22], BYTE_SLOT_B, bofs};
            3'd6:       return {1'b0, SLOT_GPIO, r[21:16]};
            default:    return r[26:16];    // Anywhere, mostly empty slots
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] pick_wdata(input logic [ADDR_W-1:0] addr);
        logic [31:0] r;
        logic [3:0]  slot;
        r    = next_rand();
        slot = (r[18:17] == 2'd0) ? 4'd0 : (r[18:17] == 2'd1) ? 4'd1 : r[22:19];
        // Bias selects toward the populated slots
        if (!addr[10] && addr[9:6] == SLOT_GPIO && is_sel_ofs(addr[5:0])) r[4:0] = {r[16], slot};
        return r;
    endfunction

    task automatic check_read(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            err_read++;
            $display("ERR %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(input logic [PIN_W-1:0] got, input logic [PIN_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            err_pins++;
            $display("ERR %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_ready++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [PIN_W-1:0] pins);
        bus_req_t txn;
        txn.addr    = addr;
        txn.wdata   = wdata;
        txn.write_n = addr[10] ? ACC_BYTE : ACC_WORD;
        txn.read_n  = ACC_NONE;
        @(posedge clk);
        req     <= txn;
        pins_in <= pins;
        @(negedge clk);
        check_ready(data_ready, 1'b1, $sformatf("ready during write 0x%03h", addr));
        @(posedge clk);
        req.write_n <= ACC_NONE;
        apply_write(addr, wdata);   // Register takes the write at this edge
        @(negedge clk);
        check_pins(pins_out, expected_pins(), $sformatf("pins after write 0x%03h", addr));
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [PIN_W-1:0] pins);
        bus_req_t          txn;
        logic [DATA_W-1:0] exp;
        int                waited;
        txn.addr    = addr;
        txn.wdata   = '0;
        txn.write_n = ACC_NONE;
        txn.read_n  = addr[10] ? ACC_BYTE : ACC_WORD;
        exp         = expected_read(addr, pins);
        @(posedge clk);
        req     <= txn;
        pins_in <= pins;
        @(negedge clk);
        check_ready(data_ready, 1'b0, $sformatf("ready early for read 0x%03h", addr));
        @(posedge clk);
        pins_in <= ~pins;   // Inputs move while the read is still requested
        @(negedge clk);
        waited = 1;
        while (!data_ready) begin
            @(negedge clk);
            waited++;
        end
        check_ready(waited == 1, 1'b1, $sformatf("ready one cycle after read 0x%03h", addr));
        check_read(data, exp, $sformatf("read 0x%03h", addr));
        @(posedge clk);
        req.read_n    <= ACC_NONE;
        read_complete <= 1'b1;
        @(negedge clk);
        check_read(data, exp, $sformatf("held read 0x%03h", addr));
        check_ready(data_ready, 1'b1, $sformatf("ready held for 0x%03h", addr));
        @(posedge clk);
        read_complete <= 1'b0;
        @(negedge clk);
        check_ready(data_ready, 1'b0, $sformatf("ready after complete 0x%03h", addr));
        check_pins(pins_out, expected_pins(), $sformatf("pins after read 0x%03h", addr));
    endtask

    task automatic print_counts();
        $display("Errors: read %0d, pins %0d, ready %0d", err_read, err_pins, err_ready);
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [31:0]       rnd;
        clk           = 1'b0;
        rst_n         = 1'b0;
        req           = '0;
        req.write_n   = ACC_NONE;
        req.read_n    = ACC_NONE;
        read_complete = 1'b0;
        pins_in       = '0;
        rand_state    = 32'h6dcd;
        err_read      = 0;
        err_pins      = 0;
        err_ready     = 0;
        reset_model();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_pins(pins_out, expected_pins(), "pins after reset");
        check_ready(data_ready, 1'b0, "ready after reset");
        for (int p = 0; p < PIN_W; p++) begin
            read_reg({1'b0, SLOT_GPIO, GPIO_SEL_BASE + 6'(4 * p)}, '0);
        end
        read_reg({1'b0, SLOT_GPIO, GPIO_OUT_OFS}, '0);
        for (int n = 0; n < NUM_TXN; n++) begin
            addr = pick_addr();
            rnd  = next_rand();
            if (rnd[31]) write_reg(addr, pick_wdata(addr), rnd[23:16]);
            else read_reg(addr, rnd[23:16]);
        end
        print_counts();
        if (err_read + err_pins + err_ready == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Ends a run where the DUT never answers
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/periph_hub.sv */
// Peripheral hub top connecting the core bus, the peripherals and the output pins
`timescale 1ns/10ps
`default_nettype none

module periph_hub (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire periph_pkg::bus_req_t          i_req,
    input  wire logic                          i_read_complete,
    input  wire logic [periph_pkg::PIN_W-1:0]  i_pins_in,
    output logic [periph_pkg::DATA_W-1:0]      o_data,
    output logic                               o_data_ready,
    output logic [periph_pkg::PIN_W-1:0]       o_pins
);
    import periph_pkg::*;

    logic [NUM_SLOTS-1:0] user_sel;
    logic [NUM_SLOTS-1:0] byte_sel;
    slot_rsp_t            user_rsp [NUM_SLOTS];
    logic [BYTE_W-1:0]    byte_rdata [NUM_SLOTS];
    slot_rsp_t            rsp;
    access_e              slot_read_n;
    bus_req_t             slot_req;
    logic                 byte_write;
    logic [PIN_W-1:0]     gpio_out;
    logic [PIN_W-1:0]     byte_a_pins;
    logic [PIN_W-1:0]     byte_b_pins;
    pin_sel_t             pin_sel [PIN_W];

    // Slots get the request with the read masked by the buffer
    always_comb begin
        slot_req        = i_req;
        slot_req.read_n = slot_read_n;
    end

    assign byte_write = i_req.write_n != ACC_NONE;

    // Unpopulated slots read zero and never stall
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_empty
        if (s != int'(SLOT_GPIO)) begin : g_user
            assign user_rsp[s] = '{rdata: '0, ready: 1'b1};
        end
        if (s != int'(BYTE_SLOT_A) && s != int'(BYTE_SLOT_B)) begin : g_byte
            assign byte_rdata[s] = '0;
        end
    end

    periph_decode u_decode (
        .i_addr       (i_req.addr),
        .i_user_rsp   (user_rsp),
        .i_byte_rdata (byte_rdata),
        .o_user_sel   (user_sel),
        .o_byte_sel   (byte_sel),
        .o_rsp        (rsp)
    );

    periph_read_buffer u_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_req.read_n),
        .i_write_n       (i_req.write_n),
        .i_rsp           (rsp),
        .i_read_complete (i_read_complete),
        .o_slot_read_n   (slot_read_n),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (slot_req),
        .i_sel      (user_sel[SLOT_GPIO]),
        .i_pins_in  (i_pins_in),
        .o_rsp      (user_rsp[SLOT_GPIO]),
        .o_gpio_out (gpio_out),
        .o_pin_sel  (pin_sel)
    );

    byte_reg_periph u_byte_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_addr    (i_req.addr[3:0]),
        .i_wdata   (i_req.wdata[BYTE_W-1:0]),
        .i_write   (byte_write && byte_sel[BYTE_SLOT_A]),
        .i_pins_in (i_pins_in),
        .o_rdata   (byte_rdata[BYTE_SLOT_A]),
        .o_pins    (byte_a_pins)
    );

    byte_reg_periph u_byte_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_addr    (i_req.addr[3:0]),
        .i_wdata   (i_req.wdata[BYTE_W-1:0]),
        .i_write   (byte_write && byte_sel[BYTE_SLOT_B]),
        .i_pins_in (i_pins_in),
        .o_rdata   (byte_rdata[BYTE_SLOT_B]),
        .o_pins    (byte_b_pins)
    );

    pin_mux u_pin_mux (
        .i_pin_sel    (pin_sel),
        .i_gpio_out   (gpio_out),
        .i_byte_a_out (byte_a_pins),
        .i_byte_b_out (byte_b_pins),
        .o_pins       (o_pins)
    );

endmodule

`default_nettype wire

/* logic/pin_mux.sv */
// Output pin router taking each pin's bit from its selected slot
`timescale 1ns/10ps
`default_nettype none

module pin_mux (
    input  wire periph_pkg::pin_sel_t          i_pin_sel [periph_pkg::PIN_W],
    input  wire logic [periph_pkg::PIN_W-1:0]  i_gpio_out,
    input  wire logic [periph_pkg::PIN_W-1:0]  i_byte_a_out,
    input  wire logic [periph_pkg::PIN_W-1:0]  i_byte_b_out,
    output logic [periph_pkg::PIN_W-1:0]       o_pins
);
    import periph_pkg::*;

    always_comb begin
        pin_sel_t sel;
        for (int p = 0; p < PIN_W; p++) begin
            sel = i_pin_sel[p];
            o_pins[p] = 1'b0;   // Empty slots drive low
            if (sel.is_byte_slot) begin
                if (sel.slot == BYTE_SLOT_A) begin
                    o_pins[p] = i_byte_a_out[p];
                end else if (sel.slot == BYTE_SLOT_B) begin
                    o_pins[p] = i_byte_b_out[p];
                end
            end else if (sel.slot == SLOT_GPIO) begin
                o_pins[p] = i_gpio_out[p];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/byte_reg_periph.sv */
// Byte-access peripheral with one output register and input read-back
`timescale 1ns/10ps
`default_nettype none

module byte_reg_periph (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [3:0]                    i_addr,
    input  wire logic [periph_pkg::BYTE_W-1:0] i_wdata,
    input  wire logic                          i_write,
    input  wire logic [periph_pkg::PIN_W-1:0]  i_pins_in,
    output logic [periph_pkg::BYTE_W-1:0]      o_rdata,
    output logic [periph_pkg::PIN_W-1:0]       o_pins
);
    import periph_pkg::*;

    logic [PIN_W-1:0] out_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (i_write && i_addr == 4'h0) begin
            out_q <= i_wdata;
        end
    end

    always_comb begin
        case (i_addr)
            4'h0:    o_rdata = out_q;
            4'h1:    o_rdata = i_pins_in;   // Live pin state
            default: o_rdata = '0;
        endcase
    end

    assign o_pins = out_q;

endmodule

`default_nettype wire

/* logic/gpio_ctrl.sv */
// GPIO block with output register, input read-back and per-pin function selects
`timescale 1ns/10ps
`default_nettype none

module gpio_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire periph_pkg::bus_req_t          i_req,
    input  wire logic                          i_sel,
    input  wire logic [periph_pkg::PIN_W-1:0]  i_pins_in,
    output periph_pkg::slot_rsp_t              o_rsp,
    output logic [periph_pkg::PIN_W-1:0]       o_gpio_out,
    output periph_pkg::pin_sel_t               o_pin_sel [periph_pkg::PIN_W]
);
    import periph_pkg::*;

    logic [PIN_W-1:0]      gpio_out;
    pin_sel_t              pin_sel [PIN_W];
    logic [SLOT_OFS_W-1:0] ofs;
    logic [PIN_IDX_W-1:0]  sel_idx;
    logic                  sel_hit;
    logic                  wr;

    assign ofs     = i_req.addr[SLOT_OFS_W-1:0];
    assign sel_idx = ofs[PIN_IDX_W+1:2];    // Word spaced, one per pin
    assign wr      = i_sel && (i_req.write_n != ACC_NONE);

    // Upper half of the slot, word aligned
    assign sel_hit = (ofs[SLOT_OFS_W-1] == GPIO_SEL_BASE[SLOT_OFS_W-1]) && (ofs[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr && ofs == GPIO_OUT_OFS) begin
            gpio_out <= i_req.wdata[PIN_W-1:0];
        end
    end

    for (genvar p = 0; p < PIN_W; p++) begin : g_sel
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                pin_sel[p] <= '{is_byte_slot: 1'b0, slot: SLOT_GPIO};  // Pins start on GPIO
            end else if (wr && sel_hit && sel_idx == PIN_IDX_W'(p)) begin
                pin_sel[p] <= pin_sel_t'(i_req.wdata[$bits(pin_sel_t)-1:0]);
            end
        end
    end

    // Read-back, always ready
    always_comb begin
        o_rsp.ready = 1'b1;
        o_rsp.rdata = '0;
        if (ofs == GPIO_OUT_OFS) begin
            o_rsp.rdata[PIN_W-1:0] = gpio_out;
        end else if (ofs == GPIO_IN_OFS) begin
            o_rsp.rdata[PIN_W-1:0] = i_pins_in;
        end else if (sel_hit) begin
            o_rsp.rdata[$bits(pin_sel_t)-1:0] = pin_sel[sel_idx];
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_pin_sel  = pin_sel;

endmodule

`default_nettype wire

/* logic/periph_read_buffer.sv */
// Read data register holding the slot response until the core completes the read
`timescale 1ns/10ps
`default_nettype none

module periph_read_buffer (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire periph_pkg::access_e           i_read_n,
    input  wire periph_pkg::access_e           i_write_n,
    input  wire periph_pkg::slot_rsp_t         i_rsp,
    input  wire logic                          i_read_complete,
    output periph_pkg::access_e                o_slot_read_n,
    output logic [periph_pkg::DATA_W-1:0]      o_data,
    output logic                               o_data_ready
);
    import periph_pkg::*;

    logic [DATA_W-1:0] data_q;
    logic              hold;
    logic              ready_q;
    logic              read_req;
    logic              capture;

    assign read_req = i_read_n != ACC_NONE;
    assign capture  = !hold && i_rsp.ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;   // Wins over a same-cycle complete
            end
            ready_q <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rsp.rdata;
        end
    end

    // Slots see no read while the buffered result is on offer
    assign o_slot_read_n = ready_q ? ACC_NONE : i_read_n;
    assign o_data        = data_q;
    assign o_data_ready  = ready_q || (i_write_n != ACC_NONE);   // Writes finish at once

    // Held data must not move until the core has taken it
    a_hold_keeps_data: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(data_q));

endmodule

`default_nettype wire

/* logic/periph_decode.sv */
// Address decoder choosing a word or byte slot and muxing its read response
`timescale 1ns/10ps
`default_nettype none

module periph_decode (
    input  wire logic [periph_pkg::ADDR_W-1:0]    i_addr,
    input  wire periph_pkg::slot_rsp_t            i_user_rsp [periph_pkg::NUM_SLOTS],
    input  wire logic [periph_pkg::BYTE_W-1:0]    i_byte_rdata [periph_pkg::NUM_SLOTS],
    output logic [periph_pkg::NUM_SLOTS-1:0]      o_user_sel,
    output logic [periph_pkg::NUM_SLOTS-1:0]      o_byte_sel,
    output periph_pkg::slot_rsp_t                 o_rsp
);
    import periph_pkg::*;

    logic [SLOT_W-1:0] user_idx;
    logic [SLOT_W-1:0] byte_idx;
    logic              byte_region;

    assign byte_region = i_addr[10];    // Upper 1 KB holds the byte slots
    assign user_idx    = i_addr[9:6];   // 64 bytes per word slot
    assign byte_idx    = i_addr[7:4];   // 16 bytes per byte slot

    always_comb begin
        o_user_sel = '0;
        o_byte_sel = '0;
        if (byte_region) begin
            o_byte_sel[byte_idx] = 1'b1;
            // Byte slots answer at once
            o_rsp.rdata = {{(DATA_W - BYTE_W){1'b0}}, i_byte_rdata[byte_idx]};
            o_rsp.ready = 1'b1;
        end else begin
            o_user_sel[user_idx] = 1'b1;
            o_rsp = i_user_rsp[user_idx];
        end
    end

    // Exactly one slot over both regions owns the bus
    always_comb begin
        if (!$isunknown(i_addr)) begin
            a_one_slot: assert ($onehot({o_user_sel, o_byte_sel}));
        end
    end

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
// Peripheral hub package with bus types, access codes and address map
`default_nettype none

package periph_pkg;

    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int PIN_W      = 8;
    localparam int NUM_SLOTS  = 16;     // Slots per region
    localparam int SLOT_W     = $clog2(NUM_SLOTS);
    localparam int PIN_IDX_W  = $clog2(PIN_W);
    localparam int SLOT_OFS_W = 6;      // 64 bytes per word slot

    // Slot numbers
    localparam logic [SLOT_W-1:0] SLOT_GPIO   = SLOT_W'(1);
    localparam logic [SLOT_W-1:0] BYTE_SLOT_A = SLOT_W'(0);
    localparam logic [SLOT_W-1:0] BYTE_SLOT_B = SLOT_W'(1);

    // GPIO register offsets inside its word slot
    localparam logic [SLOT_OFS_W-1:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [SLOT_OFS_W-1:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [SLOT_OFS_W-1:0] GPIO_SEL_BASE = 6'h20;  // One word per pin up to 0x3C

    // Core request size code, 11 means idle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        access_e           write_n;
        access_e           read_n;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ready;
    } slot_rsp_t;

    // Output function select for one pin
    typedef struct packed {
        logic              is_byte_slot;
        logic [SLOT_W-1:0] slot;
    } pin_sel_t;

endpackage

`default_nettype wire
